// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lc3b_pipe_tb
FILELIST  ?= lc3b_pipe.f
SRCS      ?= $(shell cat $(FILELIST))
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) $(SRCS)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) $(SRCS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/control_rom.sv ====
`timescale 1ns/1ps

module control_rom (
    input  lc3b_types::lc3b_word         ir_in,
    output lc3b_types::lc3b_control_word control_out
);

lc3b_types::lc3b_opcode opcode;
assign opcode = lc3b_types::lc3b_opcode'(ir_in[15:12]);

always_comb begin
    // default word that the opcodes override
    control_out.regfile_sr2_mux_sel = lc3b_types::lc3b_sr2_mux_sel_sr2;
    control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_sr2;
    control_out.general_alu_op = lc3b_types::lc3b_alu_op_pass;
    control_out.cc_load = 1'b0;
    control_out.cc_gen_mux_sel = lc3b_types::lc3b_cc_gen_mux_sel_alu;
    control_out.data_memory_write_enable = 1'b0;
    control_out.regfile_data_mux_sel = lc3b_types::lc3b_regfile_data_mux_sel_alu;
    control_out.regfile_load = 1'b0;

    case (opcode)
        lc3b_types::op_add: begin
            if (ir_in[5])
                control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
            control_out.general_alu_op = lc3b_types::lc3b_alu_op_add;
            control_out.cc_load = 1'b1;
            control_out.regfile_load = 1'b1;
        end

        lc3b_types::op_and: begin
            if (ir_in[5])
                control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
            control_out.general_alu_op = lc3b_types::lc3b_alu_op_and;
            control_out.cc_load = 1'b1;
            control_out.regfile_load = 1'b1;
        end

        lc3b_types::op_not: begin
            control_out.general_alu_op = lc3b_types::lc3b_alu_op_not;
            control_out.cc_load = 1'b1;
            control_out.regfile_load = 1'b1;
        end

        lc3b_types::op_shf: begin
            control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm4;
            if (!ir_in[4])
                control_out.general_alu_op = lc3b_types::lc3b_alu_op_sll;
            else if (!ir_in[5])
                control_out.general_alu_op = lc3b_types::lc3b_alu_op_srl;
            else
                control_out.general_alu_op = lc3b_types::lc3b_alu_op_sra;
            control_out.cc_load = 1'b1;
            control_out.regfile_load = 1'b1;
        end

        lc3b_types::op_ldr: begin
            control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_offset6_w;
            control_out.general_alu_op = lc3b_types::lc3b_alu_op_add;  // base + offset
            control_out.cc_load = 1'b1;
            control_out.cc_gen_mux_sel = lc3b_types::lc3b_cc_gen_mux_sel_mdr;
            control_out.regfile_data_mux_sel = lc3b_types::lc3b_regfile_data_mux_sel_mdr;
            control_out.regfile_load = 1'b1;
        end

        lc3b_types::op_str: begin
            control_out.regfile_sr2_mux_sel = lc3b_types::lc3b_sr2_mux_sel_dest;  // sr in 11:9
            control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_offset6_w;
            control_out.general_alu_op = lc3b_types::lc3b_alu_op_add;
            control_out.data_memory_write_enable = 1'b1;
        end

        default: begin
            control_out = '0;  // unsupported opcode becomes a bubble
        end
    endcase
end

endmodule : control_rom

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lc3b_types::lc3b_word instr,
    input  logic                 instr_valid,
    input  lc3b_types::mem_wb_t  mem_wb,
    output lc3b_types::id_ex_t   id_ex
);

lc3b_types::lc3b_word         regs [8];
lc3b_types::lc3b_control_word ctrl;
lc3b_types::lc3b_reg          sr1_idx;
lc3b_types::lc3b_reg          sr2_idx;
lc3b_types::lc3b_word         sr1_data;
lc3b_types::lc3b_word         sr2_data;
lc3b_types::id_ex_t           id_ex_next;

control_rom control_rom_i (
    .ir_in       (instr),
    .control_out (ctrl)
);

assign sr1_idx = instr[8:6];
assign sr2_idx = (ctrl.regfile_sr2_mux_sel == lc3b_types::lc3b_sr2_mux_sel_dest) ?
                 instr[11:9] : instr[2:0];

// write-through so a reader three slots behind the writer sees the new value
assign sr1_data = (mem_wb.regfile_load && mem_wb.dest == sr1_idx) ? mem_wb.data : regs[sr1_idx];
assign sr2_data = (mem_wb.regfile_load && mem_wb.dest == sr2_idx) ? mem_wb.data : regs[sr2_idx];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < 8; i++)
            regs[i] <= '0;
    end else if (mem_wb.regfile_load) begin
        regs[mem_wb.dest] <= mem_wb.data;
    end
end

always_comb begin
    id_ex_next.ctrl = ctrl;
    id_ex_next.sr1_data = sr1_data;
    id_ex_next.sr2_data = sr2_data;
    id_ex_next.imm5 = {{11{instr[4]}}, instr[4:0]};
    id_ex_next.imm4 = {12'b0, instr[3:0]};
    id_ex_next.offset6_w = {{9{instr[5]}}, instr[5:0], 1'b0};  // word offset to bytes
    id_ex_next.dest = instr[11:9];
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
        id_ex <= '0;
    else
        id_ex <= instr_valid ? id_ex_next : '0;  // empty slot loads a bubble
end

// no X may leak from the instruction stream into execute
a_id_ex_known: assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown(id_ex)
);

endmodule : decode_stage

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  lc3b_types::id_ex_t  id_ex,
    output lc3b_types::ex_mem_t ex_mem
);

lc3b_types::lc3b_word alu_a;
lc3b_types::lc3b_word alu_b;
lc3b_types::lc3b_word alu_out;
logic [3:0]           shamt;

assign alu_a = id_ex.sr1_data;
assign shamt = alu_b[3:0];  // imm4 for shf

always_comb begin
    case (id_ex.ctrl.general_alu_mux_sel)
        lc3b_types::lc3b_alu_mux_sel_imm5:      alu_b = id_ex.imm5;
        lc3b_types::lc3b_alu_mux_sel_imm4:      alu_b = id_ex.imm4;
        lc3b_types::lc3b_alu_mux_sel_offset6_w: alu_b = id_ex.offset6_w;
        default:                                alu_b = id_ex.sr2_data;
    endcase
end

always_comb begin
    case (id_ex.ctrl.general_alu_op)
        lc3b_types::lc3b_alu_op_add: alu_out = alu_a + alu_b;
        lc3b_types::lc3b_alu_op_and: alu_out = alu_a & alu_b;
        lc3b_types::lc3b_alu_op_not: alu_out = ~alu_a;
        lc3b_types::lc3b_alu_op_sll: alu_out = alu_a << shamt;
        lc3b_types::lc3b_alu_op_srl: alu_out = alu_a >> shamt;
        lc3b_types::lc3b_alu_op_sra: begin
            alu_out = lc3b_types::lc3b_word'($signed(alu_a) >>> shamt);  // keeps sign
        end
        default: alu_out = alu_a;  // pass
    endcase
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ex_mem <= '0;
    end else begin
        ex_mem.ctrl <= id_ex.ctrl;
        ex_mem.alu_out <= alu_out;
        ex_mem.store_data <= id_ex.sr2_data;
        ex_mem.dest <= id_ex.dest;
    end
end

endmodule : execute_stage

// ==== design/lc3b_pipe_top.sv ====
`timescale 1ns/1ps

module lc3b_pipe_top #(
    parameter int DATA_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lc3b_types::lc3b_word instr,
    input  logic                 instr_valid,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp  cc
);

lc3b_types::id_ex_t  id_ex;
lc3b_types::ex_mem_t ex_mem;
lc3b_types::mem_wb_t mem_wb;  // also feeds the register file

decode_stage decode_stage_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .mem_wb      (mem_wb),
    .id_ex       (id_ex)
);

execute_stage execute_stage_i (
    .clk    (clk),
    .arst_n (arst_n),
    .id_ex  (id_ex),
    .ex_mem (ex_mem)
);

memory_stage #(
    .DATA_WORDS (DATA_WORDS)
) memory_stage_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .wb_valid (wb_valid),
    .cc       (cc)
);

assign wb_dest = mem_wb.dest;
assign wb_data = mem_wb.data;

endmodule : lc3b_pipe_top

// ==== design/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
typedef logic [2:0]  lc3b_nzp;  // n, z, p

typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
    lc3b_alu_op_pass,
    lc3b_alu_op_add,
    lc3b_alu_op_and,
    lc3b_alu_op_not,
    lc3b_alu_op_sll,
    lc3b_alu_op_srl,
    lc3b_alu_op_sra
} lc3b_alu_op;

typedef enum logic [1:0] {
    lc3b_alu_mux_sel_sr2,
    lc3b_alu_mux_sel_imm5,
    lc3b_alu_mux_sel_imm4,
    lc3b_alu_mux_sel_offset6_w
} lc3b_alu_mux_sel;

typedef enum logic {lc3b_sr2_mux_sel_sr2, lc3b_sr2_mux_sel_dest} lc3b_sr2_mux_sel;
typedef enum logic {lc3b_cc_gen_mux_sel_alu, lc3b_cc_gen_mux_sel_mdr} lc3b_cc_gen_mux_sel;
typedef enum logic {
    lc3b_regfile_data_mux_sel_alu,
    lc3b_regfile_data_mux_sel_mdr
} lc3b_regfile_data_mux_sel;

// all zero is a bubble
typedef struct packed {
    lc3b_sr2_mux_sel          regfile_sr2_mux_sel;
    lc3b_alu_mux_sel          general_alu_mux_sel;
    lc3b_alu_op               general_alu_op;
    logic                     cc_load;
    lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
    logic                     data_memory_write_enable;
    lc3b_regfile_data_mux_sel regfile_data_mux_sel;
    logic                     regfile_load;
} lc3b_control_word;

typedef struct packed {
    lc3b_control_word ctrl;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;   // store data for str
    lc3b_word         imm5;       // sign extended
    lc3b_word         imm4;       // zero extended
    lc3b_word         offset6_w;  // sign extended, word scaled
    lc3b_reg          dest;
} id_ex_t;

typedef struct packed {
    lc3b_control_word ctrl;
    lc3b_word         alu_out;
    lc3b_word         store_data;
    lc3b_reg          dest;
} ex_mem_t;

typedef struct packed {
    logic     regfile_load;
    lc3b_reg  dest;
    lc3b_word data;
} mem_wb_t;

endpackage : lc3b_types

// ==== design/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int DATA_WORDS = 256
) (
    input  logic                clk,
    input  logic                arst_n,
    input  lc3b_types::ex_mem_t ex_mem,
    output lc3b_types::mem_wb_t mem_wb,
    output logic                wb_valid,
    output lc3b_types::lc3b_nzp cc
);

localparam int ADDR_W = $clog2(DATA_WORDS);

lc3b_types::lc3b_word data_mem [DATA_WORDS];
logic [ADDR_W-1:0]    addr;
lc3b_types::lc3b_word mdr;
lc3b_types::lc3b_word cc_src;
lc3b_types::lc3b_nzp  nzp;

assign addr = ex_mem.alu_out[ADDR_W:1];  // word address, wraps at depth
assign mdr = data_mem[addr];             // combinational read

always_ff @(posedge clk) begin
    if (ex_mem.ctrl.data_memory_write_enable)
        data_mem[addr] <= ex_mem.store_data;
end

assign cc_src = (ex_mem.ctrl.cc_gen_mux_sel == lc3b_types::lc3b_cc_gen_mux_sel_mdr) ?
                mdr : ex_mem.alu_out;
assign nzp = cc_src[15] ? 3'b100 : (cc_src == '0) ? 3'b010 : 3'b001;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cc <= 3'b010;
        mem_wb <= '0;
    end else begin
        if (ex_mem.ctrl.cc_load)
            cc <= nzp;
        mem_wb.regfile_load <= ex_mem.ctrl.regfile_load;
        mem_wb.dest <= ex_mem.dest;
        mem_wb.data <= (ex_mem.ctrl.regfile_data_mux_sel ==
                        lc3b_types::lc3b_regfile_data_mux_sel_mdr) ? mdr : ex_mem.alu_out;
    end
end

assign wb_valid = mem_wb.regfile_load;

a_cc_onehot: assert property (
    @(posedge clk) disable iff (!arst_n) $onehot(cc)
);

endmodule : memory_stage

// ==== lc3b_pipe.f ====
design/lc3b_types.sv
design/control_rom.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/lc3b_pipe_top.sv
sim/lc3b_pipe_tb.sv

// ==== sim/lc3b_pipe_tb.sv ====
`timescale 1ns/1ps

module lc3b_pipe_tb;

localparam int DATA_WORDS = 256;
localparam int add_imm = 0;  // instruction kinds for issue_alu
localparam int add_reg = 1;
localparam int and_imm = 2;
localparam int and_reg = 3;
localparam int not_reg = 4;
localparam int shf_sll = 5;  // srl and sra follow

typedef struct packed {
    logic [31:0]          due;
    lc3b_types::lc3b_reg  dest;
    lc3b_types::lc3b_word data;
} wb_exp_t;

logic                 clk;
logic                 arst_n;
lc3b_types::lc3b_word instr;
logic                 instr_valid;
logic                 wb_valid;
lc3b_types::lc3b_reg  wb_dest;
lc3b_types::lc3b_word wb_data;
lc3b_types::lc3b_nzp  cc;

lc3b_types::lc3b_word model [8];      // register file model
lc3b_types::lc3b_word mem_m [int];    // data memory model by word address
wb_exp_t              exp_q [$];
logic [31:0]          cycle;
logic [31:0]          lcg_state;
int                   value_errors;
int                   timeouts;

lc3b_pipe_top #(
    .DATA_WORDS (DATA_WORDS)
) dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .cc          (cc)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
endfunction

function automatic lc3b_types::lc3b_word enc_op(input logic [3:0] op,
        input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr1, input logic [5:0] low);
    return {op, dr, sr1, low};
endfunction

function automatic lc3b_types::lc3b_word sext5(input logic [4:0] imm);
    return {{11{imm[4]}}, imm};
endfunction

function automatic lc3b_types::lc3b_nzp nzp_of(input lc3b_types::lc3b_word d);
    if ($signed(d) < 0)
        return 3'b100;
    if (d == 16'h0000)
        return 3'b010;
    return 3'b001;
endfunction

function automatic int word_addr(input lc3b_types::lc3b_word base, input logic [5:0] off6);
    lc3b_types::lc3b_word byte_addr;
    byte_addr = base + {{9{off6[5]}}, off6, 1'b0};
    return int'(byte_addr[15:1]) % DATA_WORDS;  // wraps at memory depth
endfunction

// opcodes outside the core's set with junk in the low bits
function automatic lc3b_types::lc3b_word unknown_instr(input logic [15:0] x);
    logic [3:0] op;
    case (x[14:12])
        3'd0: op = lc3b_types::op_br;
        3'd1: op = lc3b_types::op_ldb;
        3'd2: op = lc3b_types::op_stb;
        3'd3: op = lc3b_types::op_jsr;
        3'd4: op = lc3b_types::op_rti;
        3'd5: op = lc3b_types::op_ldi;
        3'd6: op = lc3b_types::op_jmp;
        default: op = lc3b_types::op_trap;
    endcase
    return {op, x[11:0]};
endfunction

task automatic report_mismatch(input string name, input logic [15:0] expv,
        input logic [15:0] got);
    value_errors++;
    $display("error at %0t ns: %s expected %h, got %h", $time, name, expv, got);
endtask

// compare the writeback port against the oldest pending result
task automatic check_wb();
    wb_exp_t e;
    if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
        e = exp_q.pop_front();
        assert (wb_valid === 1'b1) else report_mismatch("wb_valid", 16'h1, {15'b0, wb_valid});
        assert (wb_dest === e.dest)
            else report_mismatch("wb_dest", {13'b0, e.dest}, {13'b0, wb_dest});
        assert (wb_data === e.data) else report_mismatch("wb_data", e.data, wb_data);
        assert (cc === nzp_of(e.data))
            else report_mismatch("cc", {13'b0, nzp_of(e.data)}, {13'b0, cc});
    end else begin
        assert (wb_valid === 1'b0) else report_mismatch("wb_valid", 16'h0, {15'b0, wb_valid});
    end
endtask

// one clock slot that drives on the rising edge and looks at the outputs mid cycle
task automatic step(input lc3b_types::lc3b_word w, input logic v);
    @(posedge clk);
    instr <= w;
    instr_valid <= v;
    cycle++;
    @(negedge clk);
    check_wb();
endtask

task automatic push_wb(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_word res);
    exp_q.push_back('{due: cycle + 32'd3, dest: dr, data: res});  // fixed 3 cycle latency
    model[dr] = res;
endtask

task automatic issue_alu(input int kind, input lc3b_types::lc3b_reg dr,
        input lc3b_types::lc3b_reg sr1, input lc3b_types::lc3b_reg sr2, input logic [4:0] imm);
    lc3b_types::lc3b_word a;
    lc3b_types::lc3b_word b;
    lc3b_types::lc3b_word res;
    lc3b_types::lc3b_word w;
    a = model[sr1];
    b = model[sr2];
    case (kind)
        add_imm: begin
            w = enc_op(lc3b_types::op_add, dr, sr1, {1'b1, imm});
            res = a + sext5(imm);
        end
        add_reg: begin
            w = enc_op(lc3b_types::op_add, dr, sr1, {3'b000, sr2});
            res = a + b;
        end
        and_imm: begin
            w = enc_op(lc3b_types::op_and, dr, sr1, {1'b1, imm});
            res = a & sext5(imm);
        end
        and_reg: begin
            w = enc_op(lc3b_types::op_and, dr, sr1, {3'b000, sr2});
            res = a & b;
        end
        not_reg: begin
            w = enc_op(lc3b_types::op_not, dr, sr1, 6'h3f);
            res = ~a;
        end
        shf_sll: begin
            w = enc_op(lc3b_types::op_shf, dr, sr1, {2'b00, imm[3:0]});
            res = a << imm[3:0];
        end
        shf_sll + 1: begin  // logical right
            w = enc_op(lc3b_types::op_shf, dr, sr1, {2'b01, imm[3:0]});
            res = a >> imm[3:0];
        end
        default: begin  // arithmetic right
            w = enc_op(lc3b_types::op_shf, dr, sr1, {2'b11, imm[3:0]});
            res = a >> imm[3:0];
            if (a[15])
                res = res | ~(16'hffff >> imm[3:0]);  // sign fill of the vacated bits
        end
    endcase
    step(w, 1'b1);
    push_wb(dr, res);
endtask

task automatic issue_str(input lc3b_types::lc3b_reg sr, input lc3b_types::lc3b_reg base,
        input logic [5:0] off6);
    mem_m[word_addr(model[base], off6)] = model[sr];
    step(enc_op(lc3b_types::op_str, sr, base, off6), 1'b1);
endtask

task automatic issue_ldr(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg base,
        input logic [5:0] off6);
    lc3b_types::lc3b_word res;
    res = mem_m[word_addr(model[base], off6)];
    step(enc_op(lc3b_types::op_ldr, dr, base, off6), 1'b1);
    push_wb(dr, res);
endtask

// bubbles for at least three slots and until every pending writeback has shown up
task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() > 0 || waited < 3) && waited < 20) begin
        step(lcg_next(), 1'b0);  // junk on instr while the strobe is low
        waited++;
    end
    if (exp_q.size() > 0) begin
        timeouts++;
        $display("timed out after %0d cycles waiting for register writebacks", waited);
        exp_q.delete();
    end
endtask

task automatic check_reset();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (wb_valid === 1'b0) else report_mismatch("wb_valid", 16'h0, {15'b0, wb_valid});
    assert (cc === 3'b010) else report_mismatch("cc", 16'h2, {13'b0, cc});
endtask

task automatic load_constants();
    logic [15:0] r;
    for (int i = 0; i < 8; i++)
        issue_alu(and_imm, 3'(i), 3'(i), 3'd0, 5'd0);
    for (int i = 0; i < 8; i++) begin  // 8 slots after the clears
        r = lcg_next();
        issue_alu(add_imm, 3'(i), 3'(i), 3'd0, r[4:0]);
    end
    drain();
endtask

task automatic run_reg_ops();
    logic [15:0] r;
    for (int i = 0; i < 9; i++) begin
        r = lcg_next();
        issue_alu((i % 3 == 0) ? add_reg : (i % 3 == 1) ? and_reg : not_reg,
                  r[2:0], r[5:3], r[8:6], 5'd0);
        drain();
    end
endtask

task automatic run_shifts();
    logic [15:0] r;
    issue_alu(and_imm, 3'd1, 3'd1, 3'd0, 5'd0);
    issue_alu(and_imm, 3'd2, 3'd2, 3'd0, 5'd0);
    drain();
    issue_alu(add_imm, 3'd1, 3'd1, 3'd0, 5'h19);  // -7
    issue_alu(add_imm, 3'd2, 3'd2, 3'd0, 5'd13);
    drain();
    issue_alu(shf_sll, 3'd2, 3'd2, 3'd0, 5'd8);  // positive 0x0d00
    drain();
    for (int i = 0; i < 6; i++) begin
        r = lcg_next();
        issue_alu(shf_sll + i % 3, 3'd3, (i < 3) ? 3'd1 : 3'd2, 3'd0, {1'b0, r[3:0]});
        drain();
    end
endtask

task automatic mem_round_trip();
    logic [15:0] r;
    r = lcg_next();
    issue_alu(and_imm, 3'd4, 3'd4, 3'd0, 5'd0);
    drain();
    issue_alu(add_imm, 3'd4, 3'd4, 3'd0, r[4:0]);
    drain();
    issue_alu(shf_sll, 3'd4, 3'd4, 3'd0, 5'd4);  // base
    issue_alu(not_reg, 3'd5, 3'd3, 3'd0, 5'd0);  // store data
    drain();
    issue_str(3'd5, 3'd4, 6'd3);
    issue_ldr(3'd6, 3'd4, 6'd3);   // one slot behind the store
    issue_str(3'd4, 3'd4, 6'h3e);  // negative offset
    issue_ldr(3'd7, 3'd4, 6'h3e);
    drain();
endtask

// sources come from r3 to r6 and dests 0, 2 and 7 are never read in the stream
task automatic stream_with_bubbles();
    logic [15:0] r;
    lc3b_types::lc3b_reg dr;
    for (int i = 0; i < 24; i++) begin
        r = lcg_next();
        dr = (r[15:14] == 2'd0) ? 3'd0 : (r[15:14] == 2'd1) ? 3'd2 : 3'd7;
        case (r[1:0])
            2'd0: step(enc_op(lc3b_types::op_add, dr, 3'd3, 6'h21), 1'b0);
            2'd1: step(unknown_instr(lcg_next()), 1'b1);
            default: issue_alu(int'(r[4:2]), dr, 3'(3 + r[6:5]), 3'(3 + r[8:7]), r[13:9]);
        endcase
    end
    drain();
endtask

initial begin
    arst_n = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    lcg_state = 32'd34307;
    cycle = '0;
    value_errors = 0;
    timeouts = 0;
    for (int i = 0; i < 8; i++)
        model[i] = '0;

    check_reset();
    load_constants();
    run_reg_ops();
    run_shifts();
    mem_round_trip();
    stream_with_bubbles();

    $display("summary: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule : lc3b_pipe_tb
